//--- rv_core_golden.txt
# Kinds: P adr data = host write, R n = run n cycles, E adr data = read and compare
# adr: host word address in hex (imem 00, dmem 40, regs 80, ctrl C0), data: 32-bit hex
# Program 1: ADDI LUI AUIPC XOR SRAI SLT SLTU SW LW BEQ BNE JAL JALR, loop on JAL x0
P 00 FFB00093
P 01 12345137
P 02 00001197
P 03 00114233
P 04 4010D293
P 05 0020A333
P 06 0020B3B3
P 07 00202423
P 08 00802403
P 09 00240463
P 0A 00100493
P 0B 00241463
P 0C 0080056F
P 0D 00100593
P 0E 00950667
P 0F 0000006F
P C0 00000001
R 24
# Program write while running must be dropped
P 03 DEADBEEF
E 03 00114233
E C0 00000001
P C0 00000000
E C0 00000000
E 80 00000000
E 81 FFFFFFFB
E 82 12345000
E 83 00001008
E 84 EDCBAFFB
E 85 FFFFFFFD
E 86 00000001
E 87 00000000
E 88 12345000
E 89 00000000
E 8A 00000034
E 8B 00000000
E 8C 0000003C
E 40 00000000
E 42 12345000
# Program 2 over words 0 to 5: SUB OR ANDI SLL SRL, loop on JAL x0
P 00 40110733
P 01 006167B3
P 02 0F00F813
P 03 006098B3
P 04 0060D933
P 05 0000006F
P C0 00000001
R 12
P C0 00000000
E 8E 12345005
E 8F 12345001
E 90 000000F0
E 91 FFFFFFF6
E 92 7FFFFFFD
E 80 00000000

//--- files.f
+incdir+.
rv_isa_pkg.sv
rv_host_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_host_port.sv
rv_core_top.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS   := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS   := rv_defs.svh
GOLDEN := rv_core_golden.txt
BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_rv_core.sv
// Testbench for the RV32I debug core
// Drives the Wishbone host port, loads programs and checks results
// Program words, run lengths and expected reads come from the golden file
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

  localparam string GOLDEN_FILE = "rv_core_golden.txt";

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [`RV_WB_AW-1:0] wb_adr;
  logic [`RV_XLEN-1:0]  wb_dat_w;
  logic [`RV_XLEN-1:0]  wb_dat_r;
  logic                 wb_ack;

  // Parsed golden records
  logic [7:0]           rec_kind [$];
  logic [`RV_WB_AW-1:0] rec_adr [$];
  logic [`RV_XLEN-1:0]  rec_dat [$];

  int     cycle_count = 0;
  int     cycle_limit = 0;
  integer seed = 92;

  rv_core_top UUT (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack
  );

  always #2 clk = ~clk;  // 4 ns period

  // Watchdog, limit is set once the golden file is parsed
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "Watchdog expired");
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns %s: got %08h, expected %08h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Ack is sampled on the falling edge where it is stable
  task automatic wait_ack();
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
  endtask

  task automatic release_bus();
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [`RV_WB_AW-1:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wait_ack();
    @(posedge clk);
    release_bus();
  endtask

  task automatic wb_read(input logic [`RV_WB_AW-1:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    dat = wb_dat_r;  // Registered data, valid with ack
    @(posedge clk);
    release_bus();
  endtask

  task automatic read_and_check(input logic [`RV_WB_AW-1:0] adr, input logic [31:0] exp);
    logic [31:0] rdata;
    wb_read(adr, rdata);
    check($sformatf("wb_dat_r (adr %02h)", adr), rdata, exp);
  endtask

  // Reads P, R and E records, skips lines starting with #
  task automatic load_golden();
    integer                fd;
    integer                code;
    logic [7:0]            kind;
    logic [`RV_WB_AW-1:0]  a;
    logic [31:0]           d;
    logic [8*160-1:0]      line;
    int                    run_total;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", GOLDEN_FILE);
      $display("SOME TESTS FAILED");
      $fatal(1, "Missing stimulus");
    end else begin
      run_total = 0;
      code = $fscanf(fd, " %c", kind);
      while (code == 1) begin
        a = '0;
        if (kind == "#") begin
          code = $fgets(line, fd);
        end else if (kind == "P" || kind == "E") begin
          code = $fscanf(fd, "%h %h", a, d);
        end else if (kind == "R") begin
          code = $fscanf(fd, "%d", d);
          run_total += int'(d);
        end else begin
          code = 0;
        end
        if (code <= 0) begin
          $display("Malformed record of kind '%c' in the golden file", kind);
          $display("SOME TESTS FAILED");
          $fatal(1, "Bad stimulus");
        end
        if (kind != "#") begin
          rec_kind.push_back(kind);
          rec_adr.push_back(a);
          rec_dat.push_back(d);
        end
        code = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
      cycle_limit = 8 * rec_kind.size() + run_total + 200;
    end
  endtask

  initial begin
    logic [31:0] words [16];
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    load_golden();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state of the host port and the core
    @(negedge clk);
    check("wb_ack", 32'(wb_ack), 32'h0);
    read_and_check(8'hC0, 32'h0);
    read_and_check(8'h85, 32'h0);
    read_and_check(8'h40, 32'h0);

    // Instruction memory write and read back while halted
    foreach (words[i]) begin
      words[i] = $random(seed);
      wb_write(8'(i), words[i]);
    end
    foreach (words[i]) begin
      read_and_check(8'(i), words[i]);
    end

    foreach (rec_kind[i]) begin
      case (rec_kind[i])
        "P":     wb_write(rec_adr[i], rec_dat[i]);
        "R":     repeat (rec_dat[i]) @(posedge clk);
        default: read_and_check(rec_adr[i], rec_dat[i]);
      endcase
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- rv_core_top.sv
// RV32I single-cycle core with a Wishbone debug port
// The host loads and reads memories and registers and sets the run bit
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`RV_WB_AW-1:0]  wb_adr,
  input  logic [`RV_XLEN-1:0]   wb_dat_w,
  output logic [`RV_XLEN-1:0]   wb_dat_r,
  output logic                  wb_ack
);

  // Host side
  logic                   run;
  logic                   imem_we;
  logic [`RV_IMEM_AW-1:0] imem_waddr;
  rv_isa_pkg::xlen_t      imem_wdata;
  logic [`RV_IMEM_AW-1:0] dbg_imem_addr;
  logic [`RV_DMEM_AW-1:0] dbg_dmem_addr;
  logic [`RV_REG_AW-1:0]  dbg_reg_addr;
  rv_isa_pkg::xlen_t      dbg_imem_data, dbg_dmem_data, dbg_reg_data;

  // Core data path
  rv_isa_pkg::xlen_t      pc, instr, next_pc, imm, alu_result, rs1_data, rs2_data;
  logic [`RV_REG_AW-1:0]  rs1_addr, rs2_addr, rd;
  rv_isa_pkg::alu_op_e    alu_op;
  rv_isa_pkg::br_cond_e   br_cond;
  rv_isa_pkg::wb_src_e    wb_src;
  logic                   alu_src_imm, a_src_pc, is_branch, is_jal, is_jalr;
  logic                   reg_we, mem_we;

  rv_host_port u_host_port (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .dbg_imem_data, .dbg_dmem_data, .dbg_reg_data,
    .wb_dat_r, .wb_ack, .run, .imem_we, .imem_waddr, .imem_wdata,
    .dbg_imem_addr, .dbg_dmem_addr, .dbg_reg_addr
  );

  rv_fetch u_fetch (
    .clk, .rst_n, .run, .next_pc, .imem_we, .imem_waddr, .imem_wdata,
    .dbg_imem_addr, .pc, .instr, .dbg_imem_data
  );

  rv_decode u_decode (
    .instr, .rs1_addr, .rs2_addr, .rd, .imm, .alu_op, .alu_src_imm, .a_src_pc,
    .is_branch, .br_cond, .is_jal, .is_jalr, .reg_we, .mem_we, .wb_src
  );

  rv_execute u_execute (
    .pc, .rs1_data, .rs2_data, .imm, .alu_op, .alu_src_imm, .a_src_pc,
    .is_branch, .br_cond, .is_jal, .is_jalr, .alu_result, .next_pc
  );

  rv_result u_result (
    .clk, .rst_n, .run, .pc, .rs1_addr, .rs2_addr, .rd, .reg_we, .mem_we, .wb_src,
    .alu_result, .dbg_dmem_addr, .dbg_reg_addr,
    .rs1_data, .rs2_data, .dbg_dmem_data, .dbg_reg_data
  );

endmodule

//--- rv_host_port.sv
// Wishbone classic slave for host debug access
// Decodes the region, registers read data, holds the run bit
// and blocks instruction memory writes while the core runs
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_host_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`RV_WB_AW-1:0]    wb_adr,
  input  logic [`RV_XLEN-1:0]     wb_dat_w,
  input  logic [`RV_XLEN-1:0]     dbg_imem_data,
  input  logic [`RV_XLEN-1:0]     dbg_dmem_data,
  input  logic [`RV_XLEN-1:0]     dbg_reg_data,
  output logic [`RV_XLEN-1:0]     wb_dat_r,
  output logic                    wb_ack,
  output logic                    run,
  output logic                    imem_we,
  output logic [`RV_IMEM_AW-1:0]  imem_waddr,
  output logic [`RV_XLEN-1:0]     imem_wdata,
  output logic [`RV_IMEM_AW-1:0]  dbg_imem_addr,
  output logic [`RV_DMEM_AW-1:0]  dbg_dmem_addr,
  output logic [`RV_REG_AW-1:0]   dbg_reg_addr
);

  rv_host_pkg::bus_state_e state;
  rv_host_pkg::region_e    region;
  logic                    req;
  logic [`RV_XLEN-1:0]     rd_data;

  assign region = rv_host_pkg::region_e'(wb_adr[`RV_WB_AW-1 -: 2]);
  assign req    = wb_cyc && wb_stb && (state == rv_host_pkg::st_idle);
  assign wb_ack = (state == rv_host_pkg::st_ack);

  assign dbg_imem_addr = wb_adr[`RV_IMEM_AW-1:0];
  assign dbg_dmem_addr = wb_adr[`RV_DMEM_AW-1:0];
  assign dbg_reg_addr  = wb_adr[`RV_REG_AW-1:0];
  assign imem_waddr    = wb_adr[`RV_IMEM_AW-1:0];
  assign imem_wdata    = wb_dat_w;
  assign imem_we       = req && wb_we && (region == rv_host_pkg::rgn_imem) && !run;

  always_comb begin
    case (region)
      rv_host_pkg::rgn_imem: rd_data = dbg_imem_data;
      rv_host_pkg::rgn_dmem: rd_data = dbg_dmem_data;
      rv_host_pkg::rgn_regs: rd_data = dbg_reg_data;
      default:               rd_data = {{(`RV_XLEN-1){1'b0}}, run};  // Control word
    endcase
  end

  // One ack cycle, then back to idle for a cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rv_host_pkg::st_idle;
      run   <= 1'b0;
    end else begin
      state <= req ? rv_host_pkg::st_ack : rv_host_pkg::st_idle;
      if (req && wb_we && (region == rv_host_pkg::rgn_ctrl)) begin
        run <= wb_dat_w[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;  // Valid while ack is high
    end
  end

  ack_single_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack
  );

endmodule

//--- rv_result.sv
// Result stage
// Register file, word-addressed data memory and writeback mux
// Both arrays have combinational host read ports
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  rv_isa_pkg::xlen_t       pc,
  input  logic [`RV_REG_AW-1:0]   rs1_addr,
  input  logic [`RV_REG_AW-1:0]   rs2_addr,
  input  logic [`RV_REG_AW-1:0]   rd,
  input  logic                    reg_we,
  input  logic                    mem_we,
  input  rv_isa_pkg::wb_src_e     wb_src,
  input  rv_isa_pkg::xlen_t       alu_result,
  input  logic [`RV_DMEM_AW-1:0]  dbg_dmem_addr,
  input  logic [`RV_REG_AW-1:0]   dbg_reg_addr,
  output rv_isa_pkg::xlen_t       rs1_data,
  output rv_isa_pkg::xlen_t       rs2_data,
  output rv_isa_pkg::xlen_t       dbg_dmem_data,
  output rv_isa_pkg::xlen_t       dbg_reg_data
);

  rv_isa_pkg::xlen_t      regs [`RV_REG_COUNT];
  rv_isa_pkg::xlen_t      dmem [`RV_DMEM_DEPTH];
  logic [`RV_DMEM_AW-1:0] dmem_addr;
  rv_isa_pkg::xlen_t      wb_data;

  assign dmem_addr = alu_result[`RV_DMEM_AW+1:2];  // Word index

  always_comb begin
    case (wb_src)
      rv_isa_pkg::src_mem: wb_data = dmem[dmem_addr];
      rv_isa_pkg::src_pc4: wb_data = pc + 32'd4;  // Link value
      default:             wb_data = alu_result;
    endcase
  end

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (run && reg_we && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (run && mem_we) begin
      dmem[dmem_addr] <= rs2_data;  // SW
    end
  end

  assign rs1_data      = regs[rs1_addr];
  assign rs2_data      = regs[rs2_addr];
  assign dbg_dmem_data = dmem[dbg_dmem_addr];
  assign dbg_reg_data  = regs[dbg_reg_addr];

  // Operand read of x0
  x0_zero_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rs1_addr == '0) |-> (rs1_data == '0)
  );

endmodule

//--- rv_execute.sv
// Execute stage
// ALU, signed branch compare and next-PC selection
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute (
  input  rv_isa_pkg::xlen_t     pc,
  input  rv_isa_pkg::xlen_t     rs1_data,
  input  rv_isa_pkg::xlen_t     rs2_data,
  input  rv_isa_pkg::xlen_t     imm,
  input  rv_isa_pkg::alu_op_e   alu_op,
  input  logic                  alu_src_imm,
  input  logic                  a_src_pc,
  input  logic                  is_branch,
  input  rv_isa_pkg::br_cond_e  br_cond,
  input  logic                  is_jal,
  input  logic                  is_jalr,
  output rv_isa_pkg::xlen_t     alu_result,
  output rv_isa_pkg::xlen_t     next_pc
);

  rv_isa_pkg::xlen_t op_a;
  rv_isa_pkg::xlen_t op_b;
  logic [4:0]        shamt;
  logic              lt_s;
  logic              lt_u;
  logic              br_taken;
  rv_isa_pkg::xlen_t jalr_target;

  assign op_a  = a_src_pc ? pc : rs1_data;  // PC for AUIPC
  assign op_b  = alu_src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];
  assign lt_s  = $signed(op_a) < $signed(op_b);
  assign lt_u  = op_a < op_b;

  always_comb begin
    case (alu_op)
      rv_isa_pkg::alu_sub:    alu_result = op_a - op_b;
      rv_isa_pkg::alu_xor:    alu_result = op_a ^ op_b;
      rv_isa_pkg::alu_or:     alu_result = op_a | op_b;
      rv_isa_pkg::alu_and:    alu_result = op_a & op_b;
      rv_isa_pkg::alu_sll:    alu_result = op_a << shamt;
      rv_isa_pkg::alu_srl:    alu_result = op_a >> shamt;
      rv_isa_pkg::alu_sra:    alu_result = rv_isa_pkg::xlen_t'($signed(op_a) >>> shamt);
      rv_isa_pkg::alu_slt:    alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_isa_pkg::alu_sltu:   alu_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_isa_pkg::alu_pass_b: alu_result = op_b;
      default:                alu_result = op_a + op_b;  // ADD, address calc
    endcase
  end

  // Branches always compare the two registers
  always_comb begin
    case (br_cond)
      rv_isa_pkg::br_beq: br_taken = (rs1_data == rs2_data);
      rv_isa_pkg::br_bne: br_taken = (rs1_data != rs2_data);
      rv_isa_pkg::br_blt: br_taken = $signed(rs1_data) < $signed(rs2_data);
      default:            br_taken = $signed(rs1_data) >= $signed(rs2_data);
    endcase
  end

  assign jalr_target = (rs1_data + imm) & ~rv_isa_pkg::xlen_t'(1);

  always_comb begin
    if (is_jal || (is_branch && br_taken)) begin
      next_pc = pc + imm;
    end else if (is_jalr) begin
      next_pc = jalr_target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

endmodule

//--- rv_decode.sv
// Decode stage
// Splits the instruction, builds the immediate and the control signals
// Undefined opcodes fall through as a no-op
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode (
  input  rv_isa_pkg::xlen_t      instr,
  output logic [`RV_REG_AW-1:0]  rs1_addr,
  output logic [`RV_REG_AW-1:0]  rs2_addr,
  output logic [`RV_REG_AW-1:0]  rd,
  output rv_isa_pkg::xlen_t      imm,
  output rv_isa_pkg::alu_op_e    alu_op,
  output logic                   alu_src_imm,
  output logic                   a_src_pc,
  output logic                   is_branch,
  output rv_isa_pkg::br_cond_e   br_cond,
  output logic                   is_jal,
  output logic                   is_jalr,
  output logic                   reg_we,
  output logic                   mem_we,
  output rv_isa_pkg::wb_src_e    wb_src
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  rv_isa_pkg::xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic rv_isa_pkg::alu_op_e alu_map(input logic [2:0] f3, input logic alt);
    rv_isa_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      3'b001:  op = rv_isa_pkg::alu_sll;
      3'b010:  op = rv_isa_pkg::alu_slt;
      3'b011:  op = rv_isa_pkg::alu_sltu;
      3'b100:  op = rv_isa_pkg::alu_xor;
      3'b101:  op = alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      3'b110:  op = rv_isa_pkg::alu_or;
      default: op = rv_isa_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode   = rv_isa_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign rd       = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm         = '0;
    alu_op      = rv_isa_pkg::alu_add;
    alu_src_imm = 1'b0;
    a_src_pc    = 1'b0;
    is_branch   = 1'b0;
    br_cond     = rv_isa_pkg::br_cond_e'({funct3[2], funct3[0]});
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    reg_we      = 1'b0;
    mem_we      = 1'b0;
    wb_src      = rv_isa_pkg::src_alu;
    case (opcode)
      rv_isa_pkg::opc_op: begin
        alu_op = alu_map(funct3, instr[30]);
        reg_we = 1'b1;
      end
      rv_isa_pkg::opc_op_imm: begin
        imm         = imm_i;
        alu_op      = alu_map(funct3, instr[30] && (funct3 == 3'b101));  // SRAI only
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      rv_isa_pkg::opc_load: begin
        imm         = imm_i;
        alu_src_imm = 1'b1;
        reg_we      = (funct3 == 3'b010);  // LW only
        wb_src      = rv_isa_pkg::src_mem;
      end
      rv_isa_pkg::opc_store: begin
        imm         = imm_s;
        alu_src_imm = 1'b1;
        mem_we      = (funct3 == 3'b010);  // SW only
      end
      rv_isa_pkg::opc_branch: begin
        imm       = imm_b;
        is_branch = !funct3[1];  // Unsigned forms not taken
      end
      rv_isa_pkg::opc_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        reg_we = 1'b1;
        wb_src = rv_isa_pkg::src_pc4;
      end
      rv_isa_pkg::opc_jalr: begin
        imm     = imm_i;
        is_jalr = 1'b1;
        reg_we  = 1'b1;
        wb_src  = rv_isa_pkg::src_pc4;
      end
      rv_isa_pkg::opc_lui: begin
        imm         = imm_u;
        alu_op      = rv_isa_pkg::alu_pass_b;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        imm         = imm_u;
        a_src_pc    = 1'b1;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- rv_fetch.sv
// Fetch stage
// Program counter and the 16-word instruction memory, with host access
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  rv_isa_pkg::xlen_t       next_pc,
  input  logic                    imem_we,
  input  logic [`RV_IMEM_AW-1:0]  imem_waddr,
  input  rv_isa_pkg::xlen_t       imem_wdata,
  input  logic [`RV_IMEM_AW-1:0]  dbg_imem_addr,
  output rv_isa_pkg::xlen_t       pc,
  output rv_isa_pkg::xlen_t       instr,
  output rv_isa_pkg::xlen_t       dbg_imem_data
);

  rv_isa_pkg::xlen_t imem [`RV_IMEM_DEPTH];

  // PC parks at 0 while halted
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // Host loads the program, no reset on the array
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_waddr] <= imem_wdata;
    end
  end

  assign instr         = imem[pc[`RV_IMEM_AW+1:2]];  // Word index of the PC
  assign dbg_imem_data = imem[dbg_imem_addr];

  // Misaligned branch or jump targets are not trapped
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    run |=> (pc[1:0] == 2'b00)
  );

endmodule

//--- rv_host_pkg.sv
// Host port types
// Address regions of the debug map and the Wishbone slave state
`include "rv_defs.svh"

package rv_host_pkg;

  // Region code from the upper two address bits
  typedef enum logic [1:0] {
    rgn_imem = `RV_RGN_IMEM,
    rgn_dmem = `RV_RGN_DMEM,
    rgn_regs = `RV_RGN_REGS,
    rgn_ctrl = `RV_RGN_CTRL
  } region_e;

  typedef enum logic {
    st_idle,
    st_ack
  } bus_state_e;

endpackage

//--- rv_isa_pkg.sv
// Instruction set types for the RV32I core
// Major opcodes, ALU operations, branch conditions and writeback source
`include "rv_defs.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;

  // Major opcodes from instr[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b   // LUI
  } alu_op_e;

  // Encoded as {funct3[2], funct3[0]}
  typedef enum logic [1:0] {
    br_beq = 2'b00,
    br_bne = 2'b01,
    br_blt = 2'b10,
    br_bge = 2'b11
  } br_cond_e;

  typedef enum logic [1:0] {
    src_alu,
    src_mem,
    src_pc4
  } wb_src_e;

endpackage

//--- rv_defs.svh
// Shared widths and sizes for the RV32I debug core
// Memory depths and the host address map used by the Wishbone port
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path
`define RV_XLEN        32

// Register file
`define RV_REG_COUNT   32
`define RV_REG_AW      5

// Instruction and data memories, in words
`define RV_IMEM_DEPTH  16
`define RV_IMEM_AW     4
`define RV_DMEM_DEPTH  16
`define RV_DMEM_AW     4

// Host word address, region code sits in bits 7:6
`define RV_WB_AW       8
`define RV_RGN_IMEM    2'b00
`define RV_RGN_DMEM    2'b01
`define RV_RGN_REGS    2'b10
`define RV_RGN_CTRL    2'b11

`endif
